// ==== source/pipePkg.sv ====
`default_nettype none

package pipePkg;

    // base opcodes of the supported rv32i subset
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opOpImm  = 7'b0010011,
        opAuipc  = 7'b0010111,
        opStore  = 7'b0100011,
        opOp     = 7'b0110011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111
    } opcode;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluXor = 3'd4,
        aluSlt = 3'd5,
        aluSll = 3'd6,
        aluSrl = 3'd7
    } aluOp;

    // writeback source select
    typedef enum logic [1:0] {
        resAlu  = 2'd0,
        resMem  = 2'd1,
        resLink = 2'd2
    } resultSrc;

    typedef enum logic [2:0] {
        fmtI = 3'd0,
        fmtS = 3'd1,
        fmtB = 3'd2,
        fmtU = 3'd3,
        fmtJ = 3'd4
    } immFormat;

    // all zero is a bubble
    typedef struct packed {
        logic     regWrite;
        resultSrc resultSel;
        logic     memWrite;
        logic     jump;
        logic     branch;
        aluOp     aluCtrl;
        logic     srcAPc;
        logic     srcBImm;
        logic     loadByte;
        logic     storeByte;
        logic     jalrTarget;
    } ctrlWord;

    typedef struct packed {
        ctrlWord     ctrl;
        logic [31:0] rd1;
        logic [31:0] rd2;
        logic [4:0]  rd;
        logic [31:0] immExt;
        logic [31:0] pc;
        logic [31:0] pcPlus4;
    } idExBundle;

    // handed on to the memory stage
    typedef struct packed {
        logic        regWrite;
        resultSrc    resultSel;
        logic        memWrite;
        logic        loadByte;
        logic        storeByte;
        logic [31:0] aluResult;
        logic [31:0] writeData;
        logic [4:0]  rd;
        logic [31:0] pcPlus4;
    } exResult;

endpackage

`default_nettype wire

// ==== source/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import pipePkg::*; (
    input  logic [31:0] instr,
    output ctrlWord     ctrl,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [4:0]  rd,
    output immFormat    fmt
);

    opcode      op;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign op     = opcode'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // lui reads x0 so the alu adds zero to the immediate
    assign rs1 = (op == opLui) ? 5'd0 : instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    always_comb begin
        ctrl = '0;
        fmt  = fmtI;
        case (op)
            opOp: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000: ctrl.aluCtrl = funct7[5] ? aluSub : aluAdd;
                    3'b111: ctrl.aluCtrl = aluAnd;
                    3'b110: ctrl.aluCtrl = aluOr;
                    3'b100: ctrl.aluCtrl = aluXor;
                    3'b010: ctrl.aluCtrl = aluSlt;
                    3'b001: ctrl.aluCtrl = aluSll;
                    3'b101: ctrl.aluCtrl = aluSrl;
                    default: ctrl = '0;
                endcase
            end
            opOpImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.srcBImm  = 1'b1;
                case (funct3)
                    3'b000: ctrl.aluCtrl = aluAdd;
                    3'b111: ctrl.aluCtrl = aluAnd;
                    3'b110: ctrl.aluCtrl = aluOr;
                    3'b100: ctrl.aluCtrl = aluXor;
                    3'b010: ctrl.aluCtrl = aluSlt;
                    default: ctrl = '0;
                endcase
            end
            opLoad: begin
                if (funct3 == 3'b010 || funct3 == 3'b100) begin
                    ctrl.regWrite  = 1'b1;
                    ctrl.resultSel = resMem;
                    ctrl.srcBImm   = 1'b1;
                    ctrl.loadByte  = funct3[2];
                end
            end
            opStore: begin
                fmt = fmtS;
                if (funct3 == 3'b010 || funct3 == 3'b000) begin
                    ctrl.memWrite  = 1'b1;
                    ctrl.srcBImm   = 1'b1;
                    ctrl.storeByte = ~funct3[1];
                end
            end
            opBranch: begin
                fmt = fmtB;
                // beq only
                if (funct3 == 3'b000) begin
                    ctrl.branch  = 1'b1;
                    ctrl.aluCtrl = aluSub;
                end
            end
            opJal: begin
                fmt            = fmtJ;
                ctrl.regWrite  = 1'b1;
                ctrl.resultSel = resLink;
                ctrl.jump      = 1'b1;
            end
            opJalr: begin
                ctrl.regWrite   = 1'b1;
                ctrl.resultSel  = resLink;
                ctrl.jump       = 1'b1;
                ctrl.srcBImm    = 1'b1;
                ctrl.jalrTarget = 1'b1;
            end
            opLui: begin
                fmt           = fmtU;
                ctrl.regWrite = 1'b1;
                ctrl.srcBImm  = 1'b1;
            end
            opAuipc: begin
                fmt           = fmtU;
                ctrl.regWrite = 1'b1;
                ctrl.srcAPc   = 1'b1;
                ctrl.srcBImm  = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    // a store must never write a register
    always_comb begin
        if (ctrl.memWrite) begin
            assert (!ctrl.regWrite)
                else $error("store decoded with regWrite set, instr %h", instr);
        end
    end

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile #(
    parameter int dataWidth = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [4:0]           rs1,
    input  logic [4:0]           rs2,
    output logic [dataWidth-1:0] rd1,
    output logic [dataWidth-1:0] rd2,
    input  logic                 wbEn,
    input  logic [4:0]           wbRd,
    input  logic [dataWidth-1:0] wbData
);

    logic [dataWidth-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && wbRd != 5'd0) begin
            regs[wbRd] <= wbData;
        end
    end

    // write-through so a same-cycle read sees the new value
    always_comb begin
        if (rs1 == 5'd0) begin
            rd1 = '0;
        end else if (wbEn && wbRd == rs1) begin
            rd1 = wbData;
        end else begin
            rd1 = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == 5'd0) begin
            rd2 = '0;
        end else if (wbEn && wbRd == rs2) begin
            rd2 = wbData;
        end else begin
            rd2 = regs[rs2];
        end
    end

endmodule

`default_nettype wire

// ==== source/immExtend.sv ====
`timescale 1ns/1ps
`default_nettype none

module immExtend import pipePkg::*; #(
    parameter int dataWidth = 32
) (
    input  logic [31:0]          instr,
    input  immFormat             fmt,
    output logic [dataWidth-1:0] immExt
);

    logic [31:0] imm32;

    always_comb begin
        case (fmt)
            fmtI: imm32 = {{20{instr[31]}}, instr[31:20]};
            fmtS: imm32 = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // branch offsets are in halfwords
            fmtB: imm32 = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            fmtU: imm32 = {instr[31:12], 12'b0};
            fmtJ: imm32 = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                           instr[30:21], 1'b0};
            default: imm32 = '0;
        endcase
    end

    // sign extend up to the datapath width
    assign immExt = dataWidth'($signed(imm32));

endmodule

`default_nettype wire

// ==== source/idExReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module idExReg import pipePkg::*; #(
    parameter int dataWidth = 32
) (
    input  logic      clk,
    input  logic      rst,
    input  idExBundle dIn,
    output idExBundle eOut
);

    localparam int bundleWidth = $bits(idExBundle);

    // five data fields plus control and rd
    if (bundleWidth != 5 * dataWidth + $bits(ctrlWord) + 5) begin : gWidthCheck
        $error("idExBundle is %0d bits, dataWidth %0d does not fit", bundleWidth,
               dataWidth);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            eOut <= '0;
        end else begin
            eOut <= dIn;
        end
    end

    // execute sees a bubble right after reset
    resetBubble: assert property (@(posedge clk) rst |=> (eOut.ctrl == '0))
        else $error("control not cleared after reset");

endmodule

`default_nettype wire

// ==== source/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage import pipePkg::*; #(
    parameter int dataWidth = 32
) (
    input  idExBundle            stage,
    output exResult              memOut,
    output logic                 branchTaken,
    output logic [dataWidth-1:0] branchTarget
);

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] jalrSum;
    logic                 regsEqual;

    // operand select
    assign opA = stage.ctrl.srcAPc ? stage.pc : stage.rd1;
    assign opB = stage.ctrl.srcBImm ? stage.immExt : stage.rd2;

    always_comb begin
        case (stage.ctrl.aluCtrl)
            aluAdd: aluResult = opA + opB;
            aluSub: aluResult = opA - opB;
            aluAnd: aluResult = opA & opB;
            aluOr:  aluResult = opA | opB;
            aluXor: aluResult = opA ^ opB;
            aluSlt: aluResult = {{(dataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
            // shift amount is the low five bits
            aluSll: aluResult = opA << opB[4:0];
            aluSrl: aluResult = opA >> opB[4:0];
            default: aluResult = '0;
        endcase
    end

    assign regsEqual   = (stage.rd1 == stage.rd2);
    assign branchTaken = stage.ctrl.jump | (stage.ctrl.branch & regsEqual);

    // jalr clears bit 0 of rs1 + imm
    assign jalrSum = stage.rd1 + stage.immExt;

    always_comb begin
        if (stage.ctrl.jalrTarget) begin
            branchTarget = {jalrSum[dataWidth-1:1], 1'b0};
        end else begin
            branchTarget = stage.pc + stage.immExt;
        end
    end

    always_comb begin
        memOut.regWrite  = stage.ctrl.regWrite;
        memOut.resultSel = stage.ctrl.resultSel;
        memOut.memWrite  = stage.ctrl.memWrite;
        memOut.loadByte  = stage.ctrl.loadByte;
        memOut.storeByte = stage.ctrl.storeByte;
        memOut.aluResult = aluResult;
        memOut.writeData = stage.rd2;
        memOut.rd        = stage.rd;
        memOut.pcPlus4   = stage.pcPlus4;
    end

    // a taken redirect needs a jump or branch in the bundle
    always_comb begin
        if (branchTaken) begin
            assert (stage.ctrl.jump || stage.ctrl.branch)
                else $error("branchTaken without jump or branch");
        end
    end

endmodule

`default_nettype wire

// ==== source/decodeExecute.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeExecute import pipePkg::*; #(
    parameter int dataWidth = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [31:0]          instr,
    input  logic [dataWidth-1:0] pc,
    input  logic                 wbEn,
    input  logic [4:0]           wbRd,
    input  logic [dataWidth-1:0] wbData,
    output exResult              memOut,
    output logic                 branchTaken,
    output logic [dataWidth-1:0] branchTarget
);

    ctrlWord              ctrl;
    immFormat             fmt;
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [4:0]           rd;
    logic [dataWidth-1:0] rd1;
    logic [dataWidth-1:0] rd2;
    logic [dataWidth-1:0] immExt;
    idExBundle            decBundle;
    idExBundle            exBundle;

    instrDecoder decoder (.instr(instr), .ctrl(ctrl), .rs1(rs1), .rs2(rs2), .rd(rd),
                          .fmt(fmt));

    regFile #(.dataWidth(dataWidth)) registers (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd1(rd1), .rd2(rd2),
        .wbEn(wbEn), .wbRd(wbRd), .wbData(wbData)
    );

    immExtend #(.dataWidth(dataWidth)) extender (.instr(instr), .fmt(fmt),
                                                 .immExt(immExt));

    // decode side of the pipeline register
    always_comb begin
        decBundle.ctrl    = ctrl;
        decBundle.rd1     = rd1;
        decBundle.rd2     = rd2;
        decBundle.rd      = rd;
        decBundle.immExt  = immExt;
        decBundle.pc      = pc;
        decBundle.pcPlus4 = pc + dataWidth'(4);
    end

    idExReg #(.dataWidth(dataWidth)) idEx (.clk(clk), .rst(rst), .dIn(decBundle),
                                           .eOut(exBundle));

    executeStage #(.dataWidth(dataWidth)) execute (
        .stage(exBundle), .memOut(memOut), .branchTaken(branchTaken),
        .branchTarget(branchTarget)
    );

endmodule

`default_nettype wire

// ==== testbench/decodeExecuteChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeExecuteChecker import pipePkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic [31:0]  instr,
    input  logic [31:0]  pc,
    input  logic         wbEn,
    input  logic [4:0]   wbRd,
    input  logic [31:0]  wbData,
    input  logic         checkEn,
    input  logic [159:0] testName,
    input  exResult      memOut,
    input  logic         branchTaken,
    input  logic [31:0]  branchTarget,
    output int           passCount,
    output int           failCount
);

    logic [31:0]  model [32];
    logic         pendValid;
    logic [159:0] pendName;
    logic         known;
    logic         chkAlu;
    logic         chkTarget;
    exResult      expOut;
    logic         expTaken;
    logic [31:0]  expTarget;
    int           errs;

    initial begin
        passCount = 0;
        failCount = 0;
        pendValid = 1'b0;
    end

    // register read as the decode stage sees it, bypass included
    function automatic logic [31:0] readReg(input logic [4:0] idx);
        if (idx == 5'd0) begin
            return '0;
        end
        if (wbEn && wbRd == idx) begin
            return wbData;
        end
        return model[idx];
    endfunction

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic subtract,
                                           input logic [31:0] x, input logic [31:0] y);
        case (f3)
            3'b000: return subtract ? x - y : x + y;
            3'b111: return x & y;
            3'b110: return x | y;
            3'b100: return x ^ y;
            3'b010: return {31'b0, $signed(x) < $signed(y)};
            3'b001: return x << y[4:0];
            default: return x >> y[4:0];
        endcase
    endfunction

    task automatic compareField(input string name, input logic [31:0] expv,
                                input logic [31:0] actv);
        if (expv !== actv) begin
            $display("Error: %s expected %h got %h", name, expv, actv);
            errs++;
        end
    endtask

    // expectation for the instruction latched at this edge
    always @(posedge clk) begin : predict
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immU;
        logic [31:0] immJ;
        a    = readReg(instr[19:15]);
        b    = readReg(instr[24:20]);
        immI = {{20{instr[31]}}, instr[31:20]};
        immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        immU = {instr[31:12], 12'h000};
        immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        expOut           = '0;
        expOut.rd        = instr[11:7];
        expOut.writeData = b;
        expOut.pcPlus4   = pc + 32'd4;
        expTaken         = 1'b0;
        expTarget        = '0;
        known            = 1'b1;
        chkAlu           = 1'b1;
        chkTarget        = 1'b0;
        case (instr[6:0])
            7'h33: begin
                expOut.regWrite  = 1'b1;
                expOut.aluResult = aluRef(instr[14:12], instr[30], a, b);
            end
            7'h13: begin
                expOut.regWrite  = 1'b1;
                expOut.aluResult = aluRef(instr[14:12], 1'b0, a, immI);
            end
            7'h03: begin
                expOut.regWrite  = 1'b1;
                expOut.resultSel = resMem;
                expOut.loadByte  = (instr[14:12] == 3'b100);
                expOut.aluResult = a + immI;
            end
            7'h23: begin
                expOut.memWrite  = 1'b1;
                expOut.storeByte = (instr[14:12] == 3'b000);
                expOut.aluResult = a + immS;
            end
            7'h63: begin
                chkAlu    = 1'b0;
                chkTarget = 1'b1;
                expTaken  = (a == b);
                expTarget = pc + immB;
            end
            7'h6f: begin
                expOut.regWrite  = 1'b1;
                expOut.resultSel = resLink;
                chkAlu           = 1'b0;
                chkTarget        = 1'b1;
                expTaken         = 1'b1;
                expTarget        = pc + immJ;
            end
            7'h67: begin
                expOut.regWrite  = 1'b1;
                expOut.resultSel = resLink;
                chkAlu           = 1'b0;
                chkTarget        = 1'b1;
                expTaken         = 1'b1;
                expTarget        = (a + immI) & 32'hffff_fffe;
            end
            7'h37: begin
                expOut.regWrite  = 1'b1;
                expOut.aluResult = immU;
            end
            7'h17: begin
                expOut.regWrite  = 1'b1;
                expOut.aluResult = pc + immU;
            end
            default: known = 1'b0;
        endcase
        // an edge taken in reset leaves a bubble in execute
        if (rst) begin
            expOut   = '0;
            expTaken = 1'b0;
            known    = 1'b0;
        end
        pendValid = checkEn;
        pendName  = testName;
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                model[i] = '0;
            end
        end else if (wbEn && wbRd != 5'd0) begin
            model[wbRd] = wbData;
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (pendValid) begin
            errs = 0;
            compareField("memOut.regWrite", 32'(expOut.regWrite), 32'(memOut.regWrite));
            compareField("memOut.memWrite", 32'(expOut.memWrite), 32'(memOut.memWrite));
            compareField("branchTaken", 32'(expTaken), 32'(branchTaken));
            if (known) begin
                compareField("memOut.resultSel", 32'(expOut.resultSel),
                             32'(memOut.resultSel));
                compareField("memOut.loadByte", 32'(expOut.loadByte), 32'(memOut.loadByte));
                compareField("memOut.storeByte", 32'(expOut.storeByte),
                             32'(memOut.storeByte));
                compareField("memOut.rd", 32'(expOut.rd), 32'(memOut.rd));
                compareField("memOut.writeData", expOut.writeData, memOut.writeData);
                compareField("memOut.pcPlus4", expOut.pcPlus4, memOut.pcPlus4);
            end
            if (known && chkAlu) begin
                compareField("memOut.aluResult", expOut.aluResult, memOut.aluResult);
            end
            if (known && chkTarget) begin
                compareField("branchTarget", expTarget, branchTarget);
            end
            if (errs == 0) begin
                passCount++;
                $display("test %0s: ok", pendName);
            end else begin
                failCount++;
                $display("test %0s: %0d mismatches", pendName, errs);
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/decodeExecuteTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeExecuteTb import pipePkg::*; ();

    // one table row per test
    typedef struct packed {
        logic [31:0]  instr;
        logic [31:0]  pc;
        logic         wbEn;
        logic [4:0]   wbRd;
        logic [31:0]  wbData;
        logic [159:0] name;
    } stimRow;

    localparam int timeoutCycles = 16;

    logic         clk;
    logic         rst;
    logic [31:0]  instr;
    logic [31:0]  pc;
    logic         wbEn;
    logic [4:0]   wbRd;
    logic [31:0]  wbData;
    logic         checkEn;
    logic [159:0] testName;
    exResult      memOut;
    logic         branchTaken;
    logic [31:0]  branchTarget;
    int           passCount;
    int           failCount;
    int           totalTests;
    stimRow       rows[$];
    logic [31:0]  seedVal;
    bit           released;
    bit           drained;

    decodeExecute #(.dataWidth(32)) dut (
        .clk(clk), .rst(rst), .instr(instr), .pc(pc), .wbEn(wbEn), .wbRd(wbRd),
        .wbData(wbData), .memOut(memOut), .branchTaken(branchTaken),
        .branchTarget(branchTarget)
    );

    decodeExecuteChecker scoreboard (
        .clk(clk), .rst(rst), .instr(instr), .pc(pc), .wbEn(wbEn), .wbRd(wbRd),
        .wbData(wbData), .checkEn(checkEn), .testName(testName), .memOut(memOut),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .passCount(passCount), .failCount(failCount)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // instruction encoders
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic addRow(input logic [31:0] i, input logic [31:0] p, input logic we,
                          input logic [4:0] wr, input logic [31:0] wd,
                          input logic [159:0] n);
        rows.push_back(stimRow'{i, p, we, wr, wd, n});
    endtask

    task automatic buildRows();
        logic [31:0] rEq;
        rEq = $urandom();
        addRow('0, '0, 1'b0, 5'd0, '0, "idle after reset");
        // even base so the jalr sum has bit 0 set
        addRow('0, '0, 1'b1, 5'd1, $urandom() & 32'hffff_fffe, "preload x1");
        addRow('0, '0, 1'b1, 5'd2, $urandom(), "preload x2");
        addRow('0, '0, 1'b1, 5'd3, $urandom(), "preload x3");
        // negative operand for signed slt
        addRow('0, '0, 1'b1, 5'd4, $urandom() | 32'h8000_0000, "preload x4");
        addRow('0, '0, 1'b1, 5'd6, rEq, "preload x6");
        addRow('0, '0, 1'b1, 5'd7, rEq, "preload x7");
        addRow(encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd5), '0, 1'b0, 5'd0, '0, "add");
        addRow(encR(7'h20, 5'd2, 5'd1, 3'b000, 5'd5), '0, 1'b0, 5'd0, '0, "sub");
        addRow(encR(7'h00, 5'd2, 5'd1, 3'b111, 5'd5), '0, 1'b0, 5'd0, '0, "and");
        addRow(encR(7'h00, 5'd2, 5'd1, 3'b110, 5'd5), '0, 1'b0, 5'd0, '0, "or");
        addRow(encR(7'h00, 5'd3, 5'd1, 3'b100, 5'd5), '0, 1'b0, 5'd0, '0, "xor");
        addRow(encR(7'h00, 5'd1, 5'd4, 3'b010, 5'd5), '0, 1'b0, 5'd0, '0, "slt");
        addRow(encR(7'h00, 5'd3, 5'd1, 3'b001, 5'd5), '0, 1'b0, 5'd0, '0, "sll");
        addRow(encR(7'h00, 5'd3, 5'd1, 3'b101, 5'd5), '0, 1'b0, 5'd0, '0, "srl");
        addRow(encI(12'hffb, 5'd1, 3'b000, 5'd8, 7'h13), '0, 1'b0, 5'd0, '0, "addi");
        addRow(encI(12'h7f0, 5'd1, 3'b111, 5'd8, 7'h13), '0, 1'b0, 5'd0, '0, "andi");
        addRow(encI(12'h0f0, 5'd2, 3'b110, 5'd8, 7'h13), '0, 1'b0, 5'd0, '0, "ori");
        addRow(encI(12'hfff, 5'd2, 3'b100, 5'd8, 7'h13), '0, 1'b0, 5'd0, '0, "xori");
        addRow(encI(12'h064, 5'd4, 3'b010, 5'd8, 7'h13), '0, 1'b0, 5'd0, '0, "slti");
        addRow(encI(12'h00c, 5'd1, 3'b010, 5'd9, 7'h03), '0, 1'b0, 5'd0, '0, "lw");
        addRow(encI(12'hffd, 5'd2, 3'b100, 5'd9, 7'h03), '0, 1'b0, 5'd0, '0, "lbu");
        addRow(encS(12'h008, 5'd2, 5'd1, 3'b010), '0, 1'b0, 5'd0, '0, "sw");
        addRow(encS(12'hff0, 5'd3, 5'd2, 3'b000), '0, 1'b0, 5'd0, '0, "sb");
        addRow(encB(13'h0010, 5'd7, 5'd6), 32'h100, 1'b0, 5'd0, '0, "beq taken");
        addRow(encB(13'h1ff8, 5'd2, 5'd1), 32'h104, 1'b0, 5'd0, '0, "beq not taken");
        addRow(encJ(21'h000800, 5'd1), 32'h200, 1'b0, 5'd0, '0, "jal");
        addRow(encI(12'h005, 5'd1, 3'b000, 5'd10, 7'h67), 32'h300, 1'b0, 5'd0, '0, "jalr");
        addRow(encU(20'habcde, 5'd11, 7'h37), 32'h310, 1'b0, 5'd0, '0, "lui");
        addRow(encU(20'h12345, 5'd12, 7'h17), 32'h400, 1'b0, 5'd0, '0, "auipc");
        addRow('0, '0, 1'b1, 5'd0, $urandom(), "write x0");
        addRow(encR(7'h00, 5'd2, 5'd0, 3'b000, 5'd13), '0, 1'b0, 5'd0, '0, "add reads x0");
        // x15 written in the same cycle that it is read
        addRow(encR(7'h00, 5'd1, 5'd15, 3'b000, 5'd14), 32'h500, 1'b1, 5'd15, $urandom(),
               "write-through");
    endtask

    task automatic waitResetRelease(output bit ok);
        int n;
        n = 0;
        while (rst && n < timeoutCycles) begin
            @(posedge clk);
            n++;
        end
        ok = !rst;
    endtask

    task automatic driveRows();
        foreach (rows[k]) begin
            instr    <= rows[k].instr;
            pc       <= rows[k].pc;
            wbEn     <= rows[k].wbEn;
            wbRd     <= rows[k].wbRd;
            wbData   <= rows[k].wbData;
            testName <= rows[k].name;
            checkEn  <= 1'b1;
            @(posedge clk);
        end
        instr   <= '0;
        wbEn    <= 1'b0;
        checkEn <= 1'b0;
    endtask

    task automatic waitAllChecked(output bit ok);
        int n;
        n = 0;
        while (passCount + failCount < totalTests && n < timeoutCycles) begin
            @(posedge clk);
            n++;
        end
        ok = (passCount + failCount == totalTests);
    endtask

    initial begin
        rst      = 1'b1;
        instr    = '0;
        pc       = '0;
        wbEn     = 1'b0;
        wbRd     = '0;
        wbData   = '0;
        checkEn  = 1'b0;
        testName = '0;
        drained  = 1'b0;
        seedVal  = $urandom(32'h67a3);
        buildRows();
        // the reset bubble test comes on top of the table
        totalTests = rows.size() + 1;
        repeat (4) @(posedge clk);
        // a jal present at the last reset edge must not reach execute
        instr    <= encJ(21'h000800, 5'd1);
        testName <= "bubble in reset";
        checkEn  <= 1'b1;
        @(posedge clk);
        rst     <= 1'b0;
        instr   <= '0;
        checkEn <= 1'b0;
        waitResetRelease(released);
        if (released) begin
            driveRows();
            waitAllChecked(drained);
        end
        if (!released) begin
            $display("timeout: reset was never released");
        end else if (!drained) begin
            $display("timeout: not every test reached the checker");
        end
        $display("tests %0d, passed %0d, failed %0d", totalTests, passCount, failCount);
        if (released && drained && failCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== decodeExecute.f ====
source/pipePkg.sv
source/instrDecoder.sv
source/regFile.sv
source/immExtend.sv
source/idExReg.sv
source/executeStage.sv
source/decodeExecute.sv
testbench/decodeExecuteChecker.sv
testbench/decodeExecuteTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the decodeExecute testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module decodeExecuteTb \
    -f decodeExecute.f -o decodeExecuteSim &&
    ./obj_dir/decodeExecuteSim | tee sim.log &&
    ! grep -q "Result: FAILED" sim.log &&
    grep -q "Result: PASSED" sim.log &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
